// File: filelist.f
logic/dds_pkg.sv
logic/key_debounce.sv
logic/wave_select.sv
logic/dds_core.sv
logic/dac_interface.sv
logic/dds_top.sv
sim/dds_sva.sv
sim/dds_checker.sv
sim/tb_dds_top.sv

// File: logic/dac_interface.sv
`timescale 1ns/1ps

module dac_interface import dds_pkg::*; (
    input  logic                    sys_clk,
    input  logic                    sys_rst_n,
    input  logic [sample_width-1:0] sample,
    input  logic                    sample_valid,
    output logic                    dac_clk,
    output logic [sample_width-1:0] dac_data
);

    logic [sample_width-1:0] next_data;

    ////////////////////////////////////////
    // Mute select
    ////////////////////////////////////////

    // Hold the analog output at zero until a waveform exists
    assign next_data = sample_valid ? sample : mid_scale;

    ////////////////////////////////////////
    // Pin register
    ////////////////////////////////////////

    // Pins come out of reset at mid-scale
    always_ff @(posedge sys_clk or negedge sys_rst_n)
    begin
        if (!sys_rst_n)
            dac_data <= mid_scale;
        else
            dac_data <= next_data;
    end

    ////////////////////////////////////////
    // DAC clock
    ////////////////////////////////////////

    // Data changes on the sys_clk rise
    // DAC latches half a period later on its own rise
    assign dac_clk = ~sys_clk;

endmodule

// File: logic/dds_core.sv
`timescale 1ns/1ps

module dds_core import dds_pkg::*; #(
    parameter logic [phase_width-1:0] freq_word = 32'h0010_0000
) (
    input  logic                    sys_clk,
    input  logic                    sys_rst_n,
    input  wave_e                   wave,
    input  logic                    wave_valid,
    output logic [sample_width-1:0] sample,
    output logic                    sample_valid
);

    logic [phase_width-1:0]  phase;
    phase_byte_u             pb;
    logic [sample_width-1:0] sine_rom [sine_depth];
    logic [5:0]              rom_idx;
    logic [sample_width-1:0] rom_val;
    logic [sample_width-1:0] sine_val;
    logic [sample_width-1:0] square_val;
    logic [sample_width-1:0] tri_val;
    logic [sample_width-1:0] saw_val;

    // Quarter wave, all entries in the upper half of the range
    initial
    begin
        $readmemh("logic/sine_quarter.hex", sine_rom);
    end

    ////////////////////////////////////////
    // Phase accumulator
    ////////////////////////////////////////

    // Free running, wraps modulo 2^32
    always_ff @(posedge sys_clk or negedge sys_rst_n)
    begin
        if (!sys_rst_n)
            phase <= '0;
        else
            phase <= phase + freq_word;
    end

    // Only the top byte addresses the waveform
    assign pb = phase[phase_width-1 -: 8];

    ////////////////////////////////////////
    // Sine by quadrant folding
    ////////////////////////////////////////

    // Odd quadrants run the table backwards, 63 - i is the bitwise inverse
    assign rom_idx = pb.as_sine.quadrant[0] ? ~pb.as_sine.index : pb.as_sine.index;
    assign rom_val = sine_rom[rom_idx];

    // Lower half wave mirrors about mid-scale
    assign sine_val = pb.as_sine.quadrant[1] ? ~rom_val : rom_val;

    ////////////////////////////////////////
    // Ramp based shapes
    ////////////////////////////////////////

    // Full scale in the first half period
    assign square_val = {8{~pb.as_ramp[7]}};

    // Rising 2p, then falling 2(255-p)+1
    assign tri_val = pb.as_ramp[7] ? {~pb.as_ramp[6:0], 1'b1}
                                   : {pb.as_ramp[6:0], 1'b0};

    assign saw_val = pb.as_ramp;

    ////////////////////////////////////////
    // Output mux
    ////////////////////////////////////////

    // Sample data itself carries no reset
    always_ff @(posedge sys_clk)
    begin
        case (wave)
            wave_sine:     sample <= sine_val;
            wave_square:   sample <= square_val;
            wave_triangle: sample <= tri_val;
            default:       sample <= saw_val;
        endcase
    end

    // Valid trails the selection by one stage, same as the sample
    always_ff @(posedge sys_clk or negedge sys_rst_n)
    begin
        if (!sys_rst_n)
            sample_valid <= 1'b0;
        else
            sample_valid <= wave_valid;
    end

endmodule

// File: logic/dds_pkg.sv
package dds_pkg;

    ////////////////////////////////////////
    // Datapath widths
    ////////////////////////////////////////

    // Phase accumulator width
    parameter int phase_width = 32;

    // Parallel DAC word
    parameter int sample_width = 8;

    // Entries in the quarter-wave sine table
    parameter int sine_depth = 64;

    // DAC code for zero output
    parameter logic [sample_width-1:0] mid_scale = 8'h80;

    ////////////////////////////////////////
    // Waveform codes
    ////////////////////////////////////////

    // Key index maps straight onto the code
    typedef enum logic [1:0] {
        wave_sine     = 2'd0,
        wave_square   = 2'd1,
        wave_triangle = 2'd2,
        wave_sawtooth = 2'd3
    } wave_e;

    // Top phase byte, read as a plain ramp or as quadrant plus table index
    typedef union packed {
        logic [7:0] as_ramp;
        struct packed {
            logic [1:0] quadrant;
            logic [5:0] index;
        } as_sine;
    } phase_byte_u;

endpackage

// File: logic/dds_top.sv
`timescale 1ns/1ps

module dds_top import dds_pkg::*; #(
    // About 20 ms at 50 MHz
    parameter int                     debounce_cnt = 999_999,
    parameter logic [phase_width-1:0] freq_word    = 32'h0010_0000
) (
    input  logic                    sys_clk,
    input  logic                    sys_rst_n,
    input  logic [3:0]              key,
    output logic [3:0]              led,
    output logic                    dac_clk,
    output logic [sample_width-1:0] dac_data
);

    wave_e                   wave;
    logic                    wave_valid;
    logic [sample_width-1:0] sample;
    logic                    sample_valid;

    ////////////////////////////////////////
    // Key input and waveform choice
    ////////////////////////////////////////

    wave_select #(
        .debounce_cnt (debounce_cnt)
    ) wave_select_i (
        .sys_clk    (sys_clk),
        .sys_rst_n  (sys_rst_n),
        .key        (key),
        .wave       (wave),
        .wave_valid (wave_valid),
        .led        (led)
    );

    ////////////////////////////////////////
    // Phase and sample generation
    ////////////////////////////////////////

    dds_core #(
        .freq_word (freq_word)
    ) dds_core_i (
        .sys_clk      (sys_clk),
        .sys_rst_n    (sys_rst_n),
        .wave         (wave),
        .wave_valid   (wave_valid),
        .sample       (sample),
        .sample_valid (sample_valid)
    );

    // DAC pins
    dac_interface dac_interface_i (
        .sys_clk      (sys_clk),
        .sys_rst_n    (sys_rst_n),
        .sample       (sample),
        .sample_valid (sample_valid),
        .dac_clk      (dac_clk),
        .dac_data     (dac_data)
    );

endmodule

// File: logic/key_debounce.sv
`timescale 1ns/1ps

module key_debounce #(
    parameter int debounce_cnt = 999_999
) (
    input  logic sys_clk,
    input  logic sys_rst_n,
    input  logic key,
    output logic press
);

    // Wide enough to hold debounce_cnt itself
    localparam int cnt_w = $clog2(debounce_cnt + 1);

    logic [1:0]       key_sync;
    logic             key_s;
    logic [cnt_w-1:0] low_cnt;
    logic             fired;

    ////////////////////////////////////////
    // Input synchronizer
    ////////////////////////////////////////

    // Idle level of the key is high
    always_ff @(posedge sys_clk or negedge sys_rst_n)
    begin
        if (!sys_rst_n)
            key_sync <= 2'b11;
        else
            key_sync <= {key_sync[0], key};
    end

    assign key_s = key_sync[1];

    ////////////////////////////////////////
    // Low-time counter and press pulse
    ////////////////////////////////////////

    always_ff @(posedge sys_clk or negedge sys_rst_n)
    begin
        if (!sys_rst_n)
        begin
            low_cnt <= '0;
            fired   <= 1'b0;
            press   <= 1'b0;
        end
        else if (key_s)
        begin
            // Any high cycle restarts the count and re-arms the pulse
            low_cnt <= '0;
            fired   <= 1'b0;
            press   <= 1'b0;
        end
        else if (low_cnt == cnt_w'(debounce_cnt))
        begin
            // Counter saturates here; only the first cycle fires
            press <= !fired;
            fired <= 1'b1;
        end
        else
        begin
            low_cnt <= low_cnt + 1'b1;
            press   <= 1'b0;
        end
    end

endmodule

// File: logic/sine_quarter.hex
// One byte per line, entry k = 128 + 127*sin(pi/2*(k+0.5)/64), k = 0 to 63
82
85
88
8B
8E
91
94
97
9A
9D
A0
A3
A6
A9
AC
AF
B2
B5
B8
BA
BD
C0
C3
C5
C8
CA
CD
CF
D2
D4
D6
D9
DB
DD
DF
E1
E3
E5
E7
E9
EA
EC
EE
EF
F1
F2
F3
F5
F6
F7
F8
F9
FA
FB
FC
FC
FD
FD
FE
FE
FF
FF
FF
FF

// File: logic/wave_select.sv
`timescale 1ns/1ps

module wave_select import dds_pkg::*; #(
    parameter int debounce_cnt = 999_999
) (
    input  logic       sys_clk,
    input  logic       sys_rst_n,
    input  logic [3:0] key,
    output wave_e      wave,
    output logic       wave_valid,
    output logic [3:0] led
);

    logic [3:0] press;
    wave_e      pick;

    ////////////////////////////////////////
    // One debouncer per key
    ////////////////////////////////////////

    for (genvar k = 0; k < 4; k++)
    begin : g_key
        key_debounce #(
            .debounce_cnt (debounce_cnt)
        ) debounce_i (
            .sys_clk   (sys_clk),
            .sys_rst_n (sys_rst_n),
            .key       (key[k]),
            .press     (press[k])
        );
    end

    // Same-cycle presses, lowest index wins
    // Scan downward so the last hit is the lowest
    always_comb
    begin
        pick = wave_sine;
        for (int i = 3; i >= 0; i--)
        begin
            if (press[i])
                pick = wave_e'(i);
        end
    end

    ////////////////////////////////////////
    // Held selection
    ////////////////////////////////////////

    always_ff @(posedge sys_clk or negedge sys_rst_n)
    begin
        if (!sys_rst_n)
        begin
            wave       <= wave_sine;
            wave_valid <= 1'b0;
        end
        else if (|press)
        begin
            wave       <= pick;
            // Sticky once any key has been accepted
            wave_valid <= 1'b1;
        end
    end

    // LEDs dark until the first press
    assign led = wave_valid ? (4'b0001 << wave) : 4'b0000;

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the DDS testbench with Verilator, then scan the log
set -o pipefail
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -f filelist.f --top-module tb_dds_top \
    && ./obj_dir/Vtb_dds_top +verilator+error+limit+1000 | tee "$LOG" \
    || { echo "Build or simulation did not complete"; exit 1; }

grep -q "TEST FAILED" "$LOG" \
    && { echo "Simulation reported failure"; exit 1; } \
    || { echo "No failure reported"; exit 0; }

// File: sim/dds_checker.sv
`timescale 1ns/1ps

module dds_checker import dds_pkg::*; #(
    parameter logic [phase_width-1:0] freq_word = 32'h0010_0000
) (
    input  logic                    sys_clk,
    input  logic                    sys_rst_n,
    input  logic [3:0]              led,
    input  logic [sample_width-1:0] dac_data,
    input  logic [3:0]              exp_led,
    input  logic                    led_chk,
    output int                      value_errs,
    output int                      other_errs
);

    logic [sample_width-1:0] sine_tab [sine_depth];
    logic [phase_width-1:0]  model_phase;
    logic [phase_width-1:0]  ph_d1;
    logic [phase_width-1:0]  ph_d2;
    logic [3:0]              led_d1;
    logic [3:0]              led_d2;
    logic [sample_width-1:0] expect_data;

    // Waveform code from the lit LED
    function automatic wave_e led_to_wave(input logic [3:0] l);
        wave_e w;
        w = wave_sine;
        for (int b = 0; b < 4; b++)
        begin
            if (l[b])
                w = wave_e'(b);
        end
        return w;
    endfunction

    // Sample value straight from the waveform definitions
    function automatic logic [7:0] wave_value(input wave_e w, input logic [7:0] p);
        int v;
        int q;
        int i;
        q = int'(p) / 64;
        i = int'(p) % 64;
        case (w)
            wave_sawtooth: v = int'(p);
            wave_square:   v = (p < 8'd128) ? 255 : 0;
            wave_triangle: v = (p < 8'd128) ? 2 * int'(p) : 2 * (255 - int'(p)) + 1;
            default:
            begin
                // Quadrants 1 and 3 read backwards, 2 and 3 flip about the midpoint
                if (q == 0)
                    v = int'(sine_tab[i]);
                else if (q == 1)
                    v = int'(sine_tab[63 - i]);
                else if (q == 2)
                    v = 255 - int'(sine_tab[i]);
                else
                    v = 255 - int'(sine_tab[63 - i]);
            end
        endcase
        return v[7:0];
    endfunction

    ////////////////////////////////////////
    // Phase model
    ////////////////////////////////////////

    // Zero after reset, one step per clock
    always @(posedge sys_clk or negedge sys_rst_n)
    begin
        if (!sys_rst_n)
            model_phase <= '0;
        else
            model_phase <= model_phase + freq_word;
    end

    ////////////////////////////////////////
    // Comparison on the falling edge
    ////////////////////////////////////////

    initial
    begin
        value_errs = 0;
        other_errs = 0;
        $readmemh("logic/sine_quarter.hex", sine_tab);
        for (int k = 0; k < sine_depth; k++)
        begin
            if ($isunknown(sine_tab[k]) || sine_tab[k] < 8'd128)
            begin
                other_errs++;
                $display("Sine table entry %0d is missing or below mid-scale", k);
            end
        end
        forever
        begin
            @(negedge sys_clk);
            if (sys_rst_n !== 1'b1)
            begin
                // History empty while in reset
                ph_d1  = '0;
                ph_d2  = '0;
                led_d1 = 4'b0000;
                led_d2 = 4'b0000;
            end
            else
            begin
                if (!$onehot0(led))
                begin
                    other_errs++;
                    $display("At %0t the LEDs show more than one waveform: %b", $time, led);
                end
                // Two cycles of latency from selection and phase to the pins
                if (led_d2 == 4'b0000)
                    expect_data = mid_scale;
                else
                    expect_data = wave_value(led_to_wave(led_d2), ph_d2[phase_width-1 -: 8]);
                if (dac_data !== expect_data)
                begin
                    value_errs++;
                    $display("[ERROR] %0t dac_data expected %02h actual %02h",
                             $time, expect_data, dac_data);
                end
                if (led_chk && led !== exp_led)
                begin
                    value_errs++;
                    $display("[ERROR] %0t led expected %b actual %b", $time, exp_led, led);
                end
                led_d2 = led_d1;
                led_d1 = led;
                ph_d2  = ph_d1;
                ph_d1  = model_phase;
            end
        end
    end

endmodule

// File: sim/dds_sva.sv
`timescale 1ns/1ps

module dds_sva import dds_pkg::*; (
    input logic                    sys_clk,
    input logic                    sys_rst_n,
    input logic [3:0]              led,
    input logic                    wave_valid,
    input logic                    dac_clk,
    input logic [sample_width-1:0] dac_data
);

    logic seen_valid;

    // Failure tally per property
    int onehot_fails = 0;
    int dark_fails   = 0;
    int mute_fails   = 0;
    int clk_fails    = 0;
    int fail_cnt;

    assign fail_cnt = onehot_fails + dark_fails + mute_fails + clk_fails;

    // Set once the first waveform is accepted
    always_ff @(posedge sys_clk or negedge sys_rst_n)
    begin
        if (!sys_rst_n)
            seen_valid <= 1'b0;
        else if (wave_valid)
            seen_valid <= 1'b1;
    end

    ////////////////////////////////////////
    // LED properties
    ////////////////////////////////////////

    // At most one waveform lit
    led_onehot: assert property (@(posedge sys_clk) disable iff (!sys_rst_n) $onehot0(led))
    else
    begin
        $error("led has more than one bit set");
        onehot_fails++;
    end

    // Once lit, some LED stays lit
    led_stays_lit: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        (led != 4'b0000) |=> (led != 4'b0000))
    else
    begin
        $error("led went dark after a waveform was selected");
        dark_fails++;
    end

    ////////////////////////////////////////
    // DAC pin properties
    ////////////////////////////////////////

    // Muted until any key accepted
    dac_muted: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        !seen_valid |-> (dac_data == mid_scale))
    else
    begin
        $error("dac_data left mid-scale before any waveform was valid");
        mute_fails++;
    end

    // DAC clock runs in antiphase
    dac_clk_inverted: assert property (@(negedge sys_clk) dac_clk != sys_clk)
    else
    begin
        $error("dac_clk is not the inverse of sys_clk");
        clk_fails++;
    end

endmodule

// File: sim/tb_dds_top.sv
`timescale 1ns/1ps

module tb_dds_top;

    localparam int          debounce_cnt = 24;
    localparam logic [31:0] freq_word    = 32'h0134_5679;
    localparam int          num_rows     = 11;

    ////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////

    // Keys pressed, bit k is key k
    localparam logic [3:0] row_mask [num_rows] = '{
        4'b0100, 4'b0001, 4'b0001, 4'b1000, 4'b0010, 4'b0100,
        4'b0100, 4'b1000, 4'b1010, 4'b0101, 4'b1100
    };
    // Random bounce cycles ahead of the clean hold
    localparam int row_bounce [num_rows] = '{10, 16, 12, 0, 14, 18, 10, 20, 0, 0, 0};
    localparam int row_hold [num_rows]   = '{8, 40, 60, 20, 35, 4, 100, 40, 40, 40, 40};
    localparam int row_rest [num_rows]   = '{60, 700, 100, 100, 600, 80, 600, 600, 300, 300, 300};
    // Short lows change nothing, lowest key wins a tie
    localparam logic [3:0] row_led [num_rows] = '{
        4'b0000, 4'b0001, 4'b0001, 4'b0001, 4'b0010, 4'b0010,
        4'b0100, 4'b1000, 4'b0010, 4'b0001, 4'b0100
    };

    logic       sys_clk;
    logic       sys_rst_n;
    logic [3:0] key;
    logic [3:0] led;
    logic       dac_clk;
    logic [7:0] dac_data;
    logic [3:0] exp_led;
    logic       led_chk;
    logic [7:0] lfsr;
    int         value_errs;
    int         other_errs;
    int         cycle_cnt;
    int         limit;

    dds_top #(
        .debounce_cnt (debounce_cnt),
        .freq_word    (freq_word)
    ) dut_i (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .key       (key),
        .led       (led),
        .dac_clk   (dac_clk),
        .dac_data  (dac_data)
    );

    dds_checker #(
        .freq_word (freq_word)
    ) checker_i (
        .sys_clk    (sys_clk),
        .sys_rst_n  (sys_rst_n),
        .led        (led),
        .dac_data   (dac_data),
        .exp_led    (exp_led),
        .led_chk    (led_chk),
        .value_errs (value_errs),
        .other_errs (other_errs)
    );

    bind dds_top dds_sva sva_i (
        .sys_clk    (sys_clk),
        .sys_rst_n  (sys_rst_n),
        .led        (led),
        .wave_valid (wave_valid),
        .dac_clk    (dac_clk),
        .dac_data   (dac_data)
    );

    // Galois form, taps for x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsr_step(input logic [7:0] s);
        logic [7:0] n;
        n = s >> 1;
        if (s[0])
            n = n ^ 8'hB8;
        return n;
    endfunction

    // Bounce, clean hold, release, then hand the expected LEDs over
    task automatic apply_row(input int r);
        logic [3:0] drive;
        for (int c = 0; c < row_bounce[r]; c++)
        begin
            drive = 4'hF;
            for (int b = 0; b < 4; b++)
            begin
                if (row_mask[r][b])
                begin
                    drive[b] = lfsr[0];
                    lfsr     = lfsr_step(lfsr);
                end
            end
            @(posedge sys_clk);
            key <= drive;
        end
        repeat (row_hold[r])
        begin
            @(posedge sys_clk);
            key <= ~row_mask[r];
        end
        repeat (row_rest[r])
        begin
            @(posedge sys_clk);
            key <= 4'hF;
        end
        @(posedge sys_clk);
        exp_led <= row_led[r];
        led_chk <= 1'b1;
        @(posedge sys_clk);
        led_chk <= 1'b0;
    endtask

    task automatic print_summary();
        $display("Summary: %0d value errors, %0d other failures, %0d assertion failures",
                 value_errs, other_errs, dut_i.sva_i.fail_cnt);
    endtask

    ////////////////////////////////////////
    // Clock, reset and stimulus
    ////////////////////////////////////////

    initial
    begin
        sys_clk = 1'b0;
        forever #10 sys_clk = ~sys_clk;
    end

    initial
    begin
        sys_rst_n = 1'b0;
        key       = 4'hF;
        exp_led   = 4'b0000;
        led_chk   = 1'b0;
        lfsr      = 8'd86;
        repeat (4) @(posedge sys_clk);
        sys_rst_n <= 1'b1;
        for (int r = 0; r < num_rows; r++)
            apply_row(r);
        repeat (4) @(posedge sys_clk);
        print_summary();
        if (value_errs + other_errs + dut_i.sva_i.fail_cnt == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

    // Table length plus reset and margin
    initial
    begin
        limit = 4 + 200;
        for (int r = 0; r < num_rows; r++)
            limit += row_bounce[r] + row_hold[r] + row_rest[r] + 2;
        cycle_cnt = 0;
        while (cycle_cnt <= limit)
        begin
            @(posedge sys_clk);
            cycle_cnt++;
        end
        $display("Timeout: stimulus did not finish within %0d cycles", limit);
        print_summary();
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule
